// ==== verilog/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Width of every operand, result and register in the execution unit
`define ALU_DATA_WIDTH 8

// Number of general registers, and the index width needed to name one
`define ALU_NUM_REGS 4
`define ALU_REG_IDX_WIDTH 2

// Host bus is word addressed, so three bits cover the whole map
`define WB_ADR_WIDTH 3

// Host data path is a full word
// Narrower registers are zero-extended on reads
`define WB_DAT_WIDTH 32

`endif

// ==== verilog/alu_op_pkg.sv ====
`include "alu_cfg.svh"

package alu_op_pkg;

    // One operand or result byte
    typedef logic [`ALU_DATA_WIDTH-1:0] alu_data_t;

    // Register number used for sources and destination
    typedef logic [`ALU_REG_IDX_WIDTH-1:0] reg_idx_t;

    // Opcodes 0 to 11 follow the arithmetic column order of the original ALU
    // Codes not listed here are undefined and produce zero
    typedef enum logic [4:0] {
        OP_PASS_A = 5'd0,
        OP_PASS_B = 5'd1,
        OP_ZERO   = 5'd2,
        OP_NEG_A  = 5'd3,
        OP_NEG_B  = 5'd4,
        OP_INC_A  = 5'd5,
        OP_INC_B  = 5'd6,
        OP_DEC_A  = 5'd7,
        OP_DEC_B  = 5'd8,
        OP_ADD    = 5'd9,
        OP_SUB_AB = 5'd10,
        OP_SUB_BA = 5'd11,
        OP_MUL_HI = 5'd16,
        OP_MUL_LO = 5'd17,
        OP_AND    = 5'd25,
        OP_OR     = 5'd26,
        OP_XOR    = 5'd27,
        OP_NOT_A  = 5'd28
    } alu_op_e;

    // Instruction word as written to INSTR, 13 bits with the op in the low bits
    typedef struct packed {
        logic     force_x_zero;
        logic     force_pass_x;
        reg_idx_t dst;
        reg_idx_t y_sel;
        reg_idx_t x_sel;
        alu_op_e  op;
    } alu_instr_t;

    // Flag pair laid out as in STATUS, carry in bit 0 and zero in bit 1
    typedef struct packed {
        logic zero;
        logic carry;
    } alu_flags_t;

endpackage

// ==== verilog/wb_bus_pkg.sv ====
`include "alu_cfg.svh"

package wb_bus_pkg;

    // Word address on the host bus
    typedef logic [`WB_ADR_WIDTH-1:0] wb_adr_t;

    // Master side of a Wishbone classic transfer
    // All fields are held steady until ack is seen
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        wb_adr_t                  adr;
        logic [`WB_DAT_WIDTH-1:0] dat_w;
    } wb_req_t;

    // Slave side of a transfer, read data is only meaningful while ack is high
    typedef struct packed {
        logic                     ack;
        logic [`WB_DAT_WIDTH-1:0] dat_r;
    } wb_rsp_t;

    // Register map
    // The reserved word reads as zero and swallows writes
    localparam wb_adr_t WB_ADR_INSTR  = 3'd0;
    localparam wb_adr_t WB_ADR_STATUS = 3'd1;
    localparam wb_adr_t WB_ADR_RESULT = 3'd2;
    localparam wb_adr_t WB_ADR_RSVD   = 3'd3;

    // r0 to r3 occupy the upper half of the map, from this address on
    localparam wb_adr_t WB_ADR_REG_BASE = 3'd4;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu (
    input  alu_op_pkg::alu_data_t  x,
    input  alu_op_pkg::alu_data_t  y,
    input  alu_op_pkg::alu_op_e    op,
    input  logic                   force_pass_x,
    input  logic                   force_x_zero,
    input  logic                   carry_in,
    output alu_op_pkg::alu_data_t  result,
    output alu_op_pkg::alu_flags_t flags
);
    import alu_op_pkg::*;

    // Constant one at the extended width, used by increments and decrements
    localparam logic [`ALU_DATA_WIDTH:0] ONE_EXT = 1;

    // Operands after the override bits have been applied
    alu_data_t x_eff;
    alu_op_e   op_eff;

    // Operands widened by one bit so the top bit catches carry or borrow
    logic [`ALU_DATA_WIDTH:0] x_ext;
    logic [`ALU_DATA_WIDTH:0] y_ext;
    logic [`ALU_DATA_WIDTH:0] cin_ext;
    logic [`ALU_DATA_WIDTH:0] wide;

    // Full double-width product, split into high and low byte ops
    logic [2*`ALU_DATA_WIDTH-1:0] product;

    // Forcing X to zero replaces the operand itself
    // Forcing pass X turns any op into pass A, so both together store zero
    assign x_eff  = force_x_zero ? '0 : x;
    assign op_eff = force_pass_x ? OP_PASS_A : op;

    assign x_ext   = {1'b0, x_eff};
    assign y_ext   = {1'b0, y};
    assign cin_ext = {{`ALU_DATA_WIDTH{1'b0}}, carry_in};

    assign product = {{`ALU_DATA_WIDTH{1'b0}}, x_eff} * {{`ALU_DATA_WIDTH{1'b0}}, y};

    // Every op is evaluated at the widened size
    // Ops without a carry leave the top bit clear
    always_comb begin
        wide = '0;
        case (op_eff)
            OP_PASS_A: wide = x_ext;
            OP_PASS_B: wide = y_ext;
            OP_ZERO:   wide = '0;
            // Negation is a subtract from zero, so the top bit is the borrow
            OP_NEG_A:  wide = '0 - x_ext;
            OP_NEG_B:  wide = '0 - y_ext;
            OP_INC_A:  wide = x_ext + ONE_EXT;
            OP_INC_B:  wide = y_ext + ONE_EXT;
            // A decrement of zero wraps and reports a borrow
            OP_DEC_A:  wide = x_ext - ONE_EXT;
            OP_DEC_B:  wide = y_ext - ONE_EXT;
            // The three chained ops consume the stored carry
            OP_ADD:    wide = x_ext + y_ext + cin_ext;
            OP_SUB_AB: wide = x_ext - y_ext - cin_ext;
            OP_SUB_BA: wide = y_ext - x_ext - cin_ext;
            OP_MUL_HI: wide = {1'b0, product[2*`ALU_DATA_WIDTH-1:`ALU_DATA_WIDTH]};
            OP_MUL_LO: wide = {1'b0, product[`ALU_DATA_WIDTH-1:0]};
            OP_AND:    wide = {1'b0, x_eff & y};
            OP_OR:     wide = {1'b0, x_eff | y};
            OP_XOR:    wide = {1'b0, x_eff ^ y};
            OP_NOT_A:  wide = {1'b0, ~x_eff};
            // Undefined codes give a clean zero with no carry
            default:   wide = '0;
        endcase
    end

    assign result = wide[`ALU_DATA_WIDTH-1:0];

    // Zero looks at the stored byte only, never at the carry bit
    always_comb begin
        flags.carry = wide[`ALU_DATA_WIDTH];
        flags.zero  = (result == '0);
    end

endmodule

// ==== verilog/alu_regfile.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  alu_op_pkg::reg_idx_t  x_sel,
    input  alu_op_pkg::reg_idx_t  y_sel,
    output alu_op_pkg::alu_data_t x_val,
    output alu_op_pkg::alu_data_t y_val,
    input  alu_op_pkg::reg_idx_t  host_idx,
    input  logic                  host_we,
    input  alu_op_pkg::alu_data_t host_wdata,
    output alu_op_pkg::alu_data_t host_rdata,
    input  logic                  exec,
    input  alu_op_pkg::reg_idx_t  dst,
    input  alu_op_pkg::alu_data_t exec_wdata
);
    import alu_op_pkg::*;

    alu_data_t regs [`ALU_NUM_REGS];

    // One write per edge
    // An executing instruction wins over a host write to the same file
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ALU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec) begin
            regs[dst] <= exec_wdata;
        end else if (host_we) begin
            regs[host_idx] <= host_wdata;
        end
    end

    // Reads are combinational, two for the ALU and one for the host bus
    assign x_val      = regs[x_sel];
    assign y_val      = regs[y_sel];
    assign host_rdata = regs[host_idx];

endmodule

// ==== verilog/alu_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_ctrl_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  wb_bus_pkg::wb_req_t    wb_req,
    output wb_bus_pkg::wb_rsp_t    wb_rsp,
    output alu_op_pkg::alu_instr_t instr,
    output logic                   carry_in,
    output logic                   exec,
    input  alu_op_pkg::alu_data_t  alu_result,
    input  alu_op_pkg::alu_flags_t alu_flags,
    output alu_op_pkg::reg_idx_t   host_idx,
    output logic                   host_we,
    output alu_op_pkg::alu_data_t  host_wdata,
    input  alu_op_pkg::alu_data_t  host_rdata
);
    import alu_op_pkg::*;
    import wb_bus_pkg::*;

    logic       ack_q;
    logic       exec_q;
    alu_instr_t instr_q;
    alu_flags_t status_q;
    alu_data_t  result_q;

    // A write is taken on the edge where ack is high
    logic wr_commit;
    logic in_reg_window;

    assign wr_commit     = wb_req.cyc & wb_req.stb & wb_req.we & ack_q;
    assign in_reg_window = (wb_req.adr >= WB_ADR_REG_BASE);

    // Ack rises one cycle after the request appears and lasts one cycle
    // The master drops stb right after, so it cannot rise twice in a row
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req.cyc & wb_req.stb & ~ack_q;
        end
    end

    // Writing INSTR arms exec for exactly the following cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q <= '0;
            exec_q  <= 1'b0;
        end else begin
            exec_q <= wr_commit && (wb_req.adr == WB_ADR_INSTR);
            if (wr_commit && (wb_req.adr == WB_ADR_INSTR)) begin
                instr_q <= alu_instr_t'(wb_req.dat_w[$bits(alu_instr_t)-1:0]);
            end
        end
    end

    // Status takes the ALU flags on exec, otherwise a host write can preset it
    // This is how the host seeds the carry before a chained add or subtract
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
            result_q <= '0;
        end else if (exec_q) begin
            status_q <= alu_flags;
            result_q <= alu_result;
        end else if (wr_commit && (wb_req.adr == WB_ADR_STATUS)) begin
            status_q <= alu_flags_t'(wb_req.dat_w[$bits(alu_flags_t)-1:0]);
        end
    end

    // The low address bits pick r0 to r3 inside the register window
    assign host_idx   = wb_req.adr[`ALU_REG_IDX_WIDTH-1:0];
    assign host_we    = wr_commit & in_reg_window;
    assign host_wdata = wb_req.dat_w[`ALU_DATA_WIDTH-1:0];

    // Read data follows the address, zero-extended to the bus width
    always_comb begin
        wb_rsp.ack = ack_q;
        case (wb_req.adr)
            WB_ADR_INSTR:  wb_rsp.dat_r = `WB_DAT_WIDTH'({instr_q});
            WB_ADR_STATUS: wb_rsp.dat_r = `WB_DAT_WIDTH'({status_q});
            WB_ADR_RESULT: wb_rsp.dat_r = `WB_DAT_WIDTH'(result_q);
            WB_ADR_RSVD:   wb_rsp.dat_r = '0;
            default:       wb_rsp.dat_r = `WB_DAT_WIDTH'(host_rdata);
        endcase
    end

    assign instr    = instr_q;
    assign exec     = exec_q;
    assign carry_in = status_q.carry;

endmodule

// ==== verilog/alu_datapath.sv ====
`timescale 1ns/1ps

module alu_datapath (
    input  logic                clk,
    input  logic                reset,
    input  wb_bus_pkg::wb_req_t wb_req,
    output wb_bus_pkg::wb_rsp_t wb_rsp
);
    import alu_op_pkg::*;

    // Latched instruction and the exec pulse that commits it
    alu_instr_t instr;
    logic       exec;
    logic       carry_in;

    // Operand values read from the register file
    alu_data_t x_val;
    alu_data_t y_val;

    // ALU outputs, stored one edge after the INSTR write
    alu_data_t  alu_result;
    alu_flags_t alu_flags;

    // Host window into the register file
    reg_idx_t  host_idx;
    logic      host_we;
    alu_data_t host_wdata;
    alu_data_t host_rdata;

    alu_ctrl_regs u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .instr      (instr),
        .carry_in   (carry_in),
        .exec       (exec),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .host_idx   (host_idx),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    alu_regfile u_regs (
        .clk        (clk),
        .reset      (reset),
        .x_sel      (instr.x_sel),
        .y_sel      (instr.y_sel),
        .x_val      (x_val),
        .y_val      (y_val),
        .host_idx   (host_idx),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .exec       (exec),
        .dst        (instr.dst),
        .exec_wdata (alu_result)
    );

    alu u_alu (
        .x            (x_val),
        .y            (y_val),
        .op           (instr.op),
        .force_pass_x (instr.force_pass_x),
        .force_x_zero (instr.force_x_zero),
        .carry_in     (carry_in),
        .result       (alu_result),
        .flags        (alu_flags)
    );

endmodule

// ==== test/alu_datapath_tb.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_datapath_tb;
    import alu_op_pkg::*;
    import wb_bus_pkg::*;

    // Bus cycles allowed before a missing ack is treated as a hang
    localparam int ACK_TIMEOUT = 20;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // LFSR state for all random stimulus
    logic [15:0] lfsr;

    // Reference state of the unit as seen by the host
    logic [`ALU_DATA_WIDTH-1:0] model_regs [`ALU_NUM_REGS];
    logic [`ALU_DATA_WIDTH-1:0] model_result;
    logic                       model_carry;
    logic                       model_zero;

    // Every opcode with a defined meaning, picked from at random
    logic [4:0] defined_ops [18] = '{OP_PASS_A, OP_PASS_B, OP_ZERO, OP_NEG_A, OP_NEG_B,
        OP_INC_A, OP_INC_B, OP_DEC_A, OP_DEC_B, OP_ADD, OP_SUB_AB, OP_SUB_BA,
        OP_MUL_HI, OP_MUL_LO, OP_AND, OP_OR, OP_XOR, OP_NOT_A};

    alu_datapath u_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step for every bit collected
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected {carry, result} straight from the opcode definitions
    function automatic logic [8:0] model_op(input logic [4:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        logic [7:0]  r;
        logic        c;
        logic [15:0] prod;
        r = 8'h00;
        c = 1'b0;
        prod = {8'h00, a} * {8'h00, b};
        case (op)
            OP_PASS_A: r = a;
            OP_PASS_B: r = b;
            OP_ZERO:   r = 8'h00;
            // Borrow out of 0 - v happens for any nonzero v
            OP_NEG_A: begin
                r = 8'h00 - a;
                c = (a != 8'h00);
            end
            OP_NEG_B: begin
                r = 8'h00 - b;
                c = (b != 8'h00);
            end
            OP_INC_A: begin
                r = a + 8'h01;
                c = (a == 8'hff);
            end
            OP_INC_B: begin
                r = b + 8'h01;
                c = (b == 8'hff);
            end
            OP_DEC_A: begin
                r = a - 8'h01;
                c = (a == 8'h00);
            end
            OP_DEC_B: begin
                r = b - 8'h01;
                c = (b == 8'h00);
            end
            OP_ADD:    {c, r} = {1'b0, a} + {1'b0, b} + {8'h00, cin};
            OP_SUB_AB: begin
                r = a - b - {7'h00, cin};
                c = ({1'b0, b} + {8'h00, cin}) > {1'b0, a};
            end
            OP_SUB_BA: begin
                r = b - a - {7'h00, cin};
                c = ({1'b0, a} + {8'h00, cin}) > {1'b0, b};
            end
            OP_MUL_HI: r = prod[15:8];
            OP_MUL_LO: r = prod[7:0];
            OP_AND:    r = a & b;
            OP_OR:     r = a | b;
            OP_XOR:    r = a ^ b;
            OP_NOT_A:  r = ~a;
            default:   r = 8'h00;
        endcase
        return {c, r};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0h actual %0h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Request is held through the ack cycle so the write commits, then released
    task automatic bus_access(input logic we, input wb_adr_t adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("Bus access to address %0d never got an ack", adr);
                $display("Done: errors found");
                $fatal(1, "Ack timeout");
            end
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat_r;
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input wb_adr_t adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'h0, data);
    endtask

    function automatic wb_adr_t reg_adr(input reg_idx_t idx);
        return WB_ADR_REG_BASE + wb_adr_t'(idx);
    endfunction

    task automatic load_reg(input reg_idx_t idx, input logic [7:0] val);
        wb_write(reg_adr(idx), {24'h0, val});
        model_regs[idx] = val;
    endtask

    // Bit 0 is carry and bit 1 is zero
    task automatic preset_status(input logic [1:0] s);
        wb_write(WB_ADR_STATUS, {30'h0, s});
        model_carry = s[0];
        model_zero  = s[1];
    endtask

    // Issue one instruction, advance the model, then read back all it touched
    task automatic run_instr(input logic [4:0] op, input reg_idx_t xs, input reg_idx_t ys,
                             input reg_idx_t dst, input logic fx0, input logic fpx,
                             input string name);
        alu_instr_t  iw;
        logic [7:0]  x_eff;
        logic [8:0]  res;
        logic [31:0] rd;
        iw.force_x_zero = fx0;
        iw.force_pass_x = fpx;
        iw.dst          = dst;
        iw.y_sel        = ys;
        iw.x_sel        = xs;
        iw.op           = alu_op_e'(op);
        x_eff = fx0 ? 8'h00 : model_regs[xs];
        res = model_op(fpx ? 5'(OP_PASS_A) : op, x_eff, model_regs[ys], model_carry);
        model_regs[dst] = res[7:0];
        model_result    = res[7:0];
        model_carry     = res[8];
        model_zero      = (res[7:0] == 8'h00);
        wb_write(WB_ADR_INSTR, 32'(iw));
        wb_read(reg_adr(dst), rd);
        check({name, " dst"}, {24'h0, model_regs[dst]}, rd);
        wb_read(WB_ADR_RESULT, rd);
        check({name, " result"}, {24'h0, model_result}, rd);
        wb_read(WB_ADR_STATUS, rd);
        check({name, " status"}, {30'h0, model_zero, model_carry}, rd);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [4:0]  op;
        reg_idx_t    xs;
        reg_idx_t    ys;
        reg_idx_t    dst;
        int          idx;
        wb_req = '0;
        reset  = 1'b1;
        lfsr   = 16'd11566;
        model_result = '0;
        model_carry  = 1'b0;
        model_zero   = 1'b0;
        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Whole map reads zero straight out of reset
        for (int a = 0; a < 8; a++) begin
            wb_read(wb_adr_t'(a), rd);
            check("reset readback", 32'h0, rd);
        end

        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            take_bits(8, v);
            load_reg(reg_idx_t'(i), v[7:0]);
        end
        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            wb_read(reg_adr(reg_idx_t'(i)), rd);
            check("register readback", {24'h0, model_regs[i]}, rd);
        end
        wb_write(WB_ADR_RSVD, 32'hffff_ffff);
        wb_read(WB_ADR_RSVD, rd);
        check("reserved address", 32'h0, rd);

        // When no status preset happens the carry chains from the previous op
        repeat (200) begin
            take_bits(5, v);
            idx = int'(v % 32'd18);
            op = defined_ops[idx];
            take_bits(2, v);
            xs = v[1:0];
            take_bits(2, v);
            ys = v[1:0];
            take_bits(2, v);
            dst = v[1:0];
            take_bits(8, v);
            load_reg(xs, v[7:0]);
            take_bits(8, v);
            load_reg(ys, v[7:0]);
            take_bits(1, v);
            if (v[0]) begin
                take_bits(2, v);
                preset_status(v[1:0]);
            end
            run_instr(op, xs, ys, dst, 1'b0, 1'b0, "random instr");
        end

        // Multiply and logic ops never report a carry
        for (int k = 12; k < 18; k++) begin
            repeat (6) begin
                take_bits(16, v);
                load_reg(2'd1, v[7:0]);
                load_reg(2'd2, v[15:8]);
                preset_status(2'b01);
                run_instr(defined_ops[k], 2'd1, 2'd2, 2'd3, 1'b0, 1'b0, "mul logic");
            end
        end

        // With X forced to zero an add returns B plus the carry
        // X is kept nonzero so that an ignored force changes the sum
        take_bits(16, v);
        load_reg(2'd1, v[7:0] | 8'h01);
        load_reg(2'd2, v[15:8]);
        preset_status(2'b01);
        run_instr(OP_ADD, 2'd1, 2'd2, 2'd3, 1'b1, 1'b0, "force x zero");
        run_instr(OP_SUB_AB, 2'd1, 2'd2, 2'd0, 1'b0, 1'b1, "force pass x");
        // NOT A of a zeroed X is all ones, so only the pass override gives zero here
        run_instr(OP_NOT_A, 2'd1, 2'd2, 2'd0, 1'b1, 1'b1, "both forces");

        // Codes outside the defined set store zero
        foreach (defined_ops[k]) begin
            if (k < 3) begin
                take_bits(8, v);
                load_reg(2'd2, v[7:0] | 8'h01);
                preset_status(2'b01);
                op = (k == 0) ? 5'd12 : ((k == 1) ? 5'd21 : 5'd31);
                run_instr(op, 2'd2, 2'd2, 2'd2, 1'b0, 1'b0, "undefined op");
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== alu_datapath.f ====
+incdir+verilog
verilog/alu_op_pkg.sv
verilog/wb_bus_pkg.sv
verilog/alu.sv
verilog/alu_regfile.sv
verilog/alu_ctrl_regs.sv
verilog/alu_datapath.sv
test/alu_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
# A failing check ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary \
    -f alu_datapath.f \
    --top-module alu_datapath_tb \
    -o alu_datapath_sim

./obj_dir/alu_datapath_sim
